//--- div_msg_pkg.sv
// --------------------------------------
// divider message types
// request and response formats of the iterative integer divider
// --------------------------------------

package div_msg_pkg;

  // --------------------------------------
  // operand width
  // --------------------------------------

  // fixed, the packed messages below are built around it
  localparam int unsigned div_width = 32;

  // --------------------------------------
  // function code
  // --------------------------------------

  // one bit is enough for the two supported functions
  typedef enum logic {
    // plain magnitudes, no sign handling
    div_fn_unsigned = 1'b0,
    // two's complement operands, sign fixed up on the result
    div_fn_signed   = 1'b1
  } div_fn_e;

  // --------------------------------------
  // request message
  // --------------------------------------

  // 65 bits total, fn sits in the top bit
  typedef struct packed {
    // signed or unsigned division
    div_fn_e               fn;
    // dividend
    logic [div_width-1:0]  a;
    // divisor
    logic [div_width-1:0]  b;
  } div_req_msg_t;

  // --------------------------------------
  // response message
  // --------------------------------------

  // 64 bits, remainder in the upper half, quotient in the lower half
  typedef struct packed {
    // remainder, takes the sign of the dividend
    logic [div_width-1:0]  rem;
    // quotient, negative when operand signs differ
    logic [div_width-1:0]  quot;
  } div_resp_msg_t;

endpackage

//--- div_ctrl_pkg.sv
// --------------------------------------
// divider control types
// FSM state and the control/status bundles between ctrl and datapath
// --------------------------------------

package div_ctrl_pkg;

  // --------------------------------------
  // FSM state
  // --------------------------------------

  typedef enum logic [1:0] {
    // waiting for a request, req_rdy high
    st_idle = 2'd0,
    // running the shift-subtract iterations
    st_calc = 2'd1,
    // result held until the consumer takes it
    st_done = 2'd2
  } div_state_e;

  // --------------------------------------
  // control to datapath
  // --------------------------------------

  // 5 bits, all zero means the datapath holds its registers
  typedef struct packed {
    // capture operands, sign flags and the counter start value
    logic load;
    // one shift-subtract iteration this edge
    logic step;
    // a register takes the iteration result, not the initial value
    logic a_from_sub;
    // trial subtraction went negative, keep shifted value with q bit 0
    logic restore;
    // counter counts down instead of reloading
    logic cnt_dec;
  } div_ctrl_t;

  // --------------------------------------
  // datapath to control
  // --------------------------------------

  // 2 bits
  typedef struct packed {
    // sign bit of the trial subtraction
    logic sub_neg;
    // iteration counter has reached zero, this is the last step
    logic cnt_zero;
  } div_status_t;

endpackage

//--- int_div_dpath.sv
// --------------------------------------
// iterative divider datapath
// restoring shift-subtract on a 65-bit register with sign correction
// --------------------------------------

`timescale 1ns/1ps

module int_div_dpath (
  input  logic                       clk,
  input  logic                       reset,

  // request payload, only sampled on load
  input  div_msg_pkg::div_req_msg_t  req_msg,

  // control in, status out
  input  div_ctrl_pkg::div_ctrl_t    ctrl,
  output div_ctrl_pkg::div_status_t  status,

  // result, valid while the FSM sits in st_done
  output div_msg_pkg::div_resp_msg_t resp_msg
);

  // --------------------------------------
  // widths
  // --------------------------------------

  // operand width
  localparam int unsigned dw = div_msg_pkg::div_width;
  // working register width, one guard bit above remainder and quotient
  localparam int unsigned aw = 2 * dw + 1;
  // iteration counter width
  localparam int unsigned cw = $clog2(dw);
  // counter start, last step runs with the counter at zero
  localparam logic [cw-1:0] cnt_start = cw'(dw - 1);

  // --------------------------------------
  // declarations
  // --------------------------------------

  // operand unsigning
  logic          req_signed;
  logic          a_sign;
  logic          b_sign;
  logic [dw-1:0] a_mag;
  logic [dw-1:0] b_mag;
  logic [dw-1:0] a_unsigned;
  logic [dw-1:0] b_unsigned;

  // working registers and their next values
  logic [aw-1:0] a_init;
  logic [aw-1:0] b_init;
  logic [aw-1:0] a_reg;
  logic [aw-1:0] b_reg;
  logic [aw-1:0] a_shift;
  logic [aw-1:0] sub_out;
  logic [aw-1:0] a_keep;
  logic [aw-1:0] a_restore;
  logic [aw-1:0] a_step_next;
  logic [aw-1:0] a_next;

  // iteration counter
  logic [cw-1:0] cnt_reg;
  logic [cw-1:0] cnt_next;

  // result sign flags, captured with the operands
  logic          quot_neg_reg;
  logic          rem_neg_reg;

  // result magnitudes and signed results
  logic [dw-1:0] quot_mag;
  logic [dw-1:0] rem_mag;
  logic [dw-1:0] quot_signed;
  logic [dw-1:0] rem_signed;

  // --------------------------------------
  // operand unsigning
  // --------------------------------------

  assign req_signed = (req_msg.fn == div_msg_pkg::div_fn_signed);

  // msb is the two's complement sign
  assign a_sign = req_msg.a[dw-1];
  assign b_sign = req_msg.b[dw-1];

  // magnitude of a negative operand, -2^31 maps onto itself as unsigned 2^31
  assign a_mag = a_sign ? (~req_msg.a + dw'(1)) : req_msg.a;
  assign b_mag = b_sign ? (~req_msg.b + dw'(1)) : req_msg.b;

  // unsigned requests pass straight through
  assign a_unsigned = req_signed ? a_mag : req_msg.a;
  assign b_unsigned = req_signed ? b_mag : req_msg.b;

  // dividend sits in the quotient half, divisor aligned to the remainder half
  assign a_init = {{(dw + 1){1'b0}}, a_unsigned};
  assign b_init = {1'b0, b_unsigned, {dw{1'b0}}};

  // --------------------------------------
  // shift-subtract step
  // --------------------------------------

  // shift partial remainder and quotient left together
  assign a_shift = {a_reg[aw-2:0], 1'b0};

  // trial subtraction of the aligned divisor
  assign sub_out = a_shift - b_reg;

  // non-negative difference, keep it and set quotient bit
  assign a_keep = {sub_out[aw-1:1], 1'b1};

  // negative difference, fall back to the shifted value, quotient bit 0
  assign a_restore = {a_shift[aw-1:1], 1'b0};

  assign a_step_next = ctrl.restore ? a_restore : a_keep;
  assign a_next      = ctrl.a_from_sub ? a_step_next : a_init;

  // counter reloads on load, counts down on step
  assign cnt_next = ctrl.cnt_dec ? (cnt_reg - cw'(1)) : cnt_start;

  // --------------------------------------
  // status back to control
  // --------------------------------------

  // guard bit is set exactly when the trial difference went negative
  assign status.sub_neg  = sub_out[aw-1];
  assign status.cnt_zero = (cnt_reg == '0);

  // --------------------------------------
  // registers
  // --------------------------------------

  // counter is control state
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg <= '0;
    end else if (ctrl.load || ctrl.step) begin
      cnt_reg <= cnt_next;
    end
  end

  // working register, written on load and on every step
  always_ff @(posedge clk) begin
    if (ctrl.load || ctrl.step) begin
      a_reg <= a_next;
    end
  end

  // divisor and sign flags only change with a new request
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      b_reg        <= b_init;
      // quotient negative when exactly one operand is negative
      quot_neg_reg <= req_signed & (a_sign ^ b_sign);
      // remainder follows the dividend
      rem_neg_reg  <= req_signed & a_sign;
    end
  end

  // --------------------------------------
  // result sign correction
  // --------------------------------------

  // quotient in the low half, remainder just above it
  assign quot_mag = a_reg[dw-1:0];
  assign rem_mag  = a_reg[2*dw-1:dw];

  assign quot_signed = quot_neg_reg ? (~quot_mag + dw'(1)) : quot_mag;
  assign rem_signed  = rem_neg_reg ? (~rem_mag + dw'(1)) : rem_mag;

  assign resp_msg.rem  = rem_signed;
  assign resp_msg.quot = quot_signed;

endmodule

//--- int_div_ctrl.sv
// --------------------------------------
// iterative divider control
// idle/calc/done FSM driving datapath enables and the val/rdy strobes
// --------------------------------------

`timescale 1ns/1ps

module int_div_ctrl (
  input  logic                      clk,
  input  logic                      reset,

  // request side
  input  logic                      req_val,
  output logic                      req_rdy,

  // response side
  output logic                      resp_val,
  input  logic                      resp_rdy,

  // datapath status in, control out
  input  div_ctrl_pkg::div_status_t status,
  output div_ctrl_pkg::div_ctrl_t   ctrl
);

  // --------------------------------------
  // declarations
  // --------------------------------------

  div_ctrl_pkg::div_state_e state;
  div_ctrl_pkg::div_state_e state_next;

  // transfer strobes
  logic req_go;
  logic resp_go;

  // request transfers while idle and the producer has one
  assign req_go  = req_val && req_rdy;
  // response leaves when the consumer is ready
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------
  // state register
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_ctrl_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------
  // next state
  // --------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      div_ctrl_pkg::st_idle: begin
        // operands load on the same edge
        if (req_go) begin
          state_next = div_ctrl_pkg::st_calc;
        end
      end
      div_ctrl_pkg::st_calc: begin
        // last step is the one taken with the counter at zero
        if (status.cnt_zero) begin
          state_next = div_ctrl_pkg::st_done;
        end
      end
      div_ctrl_pkg::st_done: begin
        // hold the result until the consumer takes it
        if (resp_go) begin
          state_next = div_ctrl_pkg::st_idle;
        end
      end
      default: begin
        state_next = div_ctrl_pkg::st_idle;
      end
    endcase
  end

  // --------------------------------------
  // outputs
  // --------------------------------------

  // all outputs decode from the state, load also needs req_val
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    ctrl     = '0;
    case (state)
      div_ctrl_pkg::st_idle: begin
        req_rdy   = 1'b1;
        // capture operands only on an actual transfer
        ctrl.load = req_val;
      end
      div_ctrl_pkg::st_calc: begin
        ctrl.step       = 1'b1;
        ctrl.a_from_sub = 1'b1;
        ctrl.cnt_dec    = 1'b1;
        // negative trial difference means quotient bit 0
        ctrl.restore    = status.sub_neg;
      end
      div_ctrl_pkg::st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

//--- int_div_iterative.sv
// --------------------------------------
// iterative integer divider
// 32-bit signed/unsigned division, one request in flight at a time
// --------------------------------------

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,

  // request, transfers when req_val and req_rdy are both high
  input  div_msg_pkg::div_req_msg_t  req_msg,
  input  logic                       req_val,
  output logic                       req_rdy,

  // response, transfers when resp_val and resp_rdy are both high
  output div_msg_pkg::div_resp_msg_t resp_msg,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // control fields from FSM to datapath
  div_ctrl_pkg::div_ctrl_t   dpath_ctrl;
  // status fields from datapath to FSM
  div_ctrl_pkg::div_status_t dpath_status;

  // --------------------------------------
  // datapath
  // --------------------------------------

  // only the datapath sees the request payload
  int_div_dpath dpath (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .ctrl     (dpath_ctrl),
    .status   (dpath_status),
    .resp_msg (resp_msg)
  );

  // --------------------------------------
  // control
  // --------------------------------------

  // owns both handshakes
  int_div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .status   (dpath_status),
    .ctrl     (dpath_ctrl)
  );

endmodule

//--- int_div_assert.sv
// --------------------------------------
// divider handshake assertions
// bound to the top level of the iterative divider
// --------------------------------------

`timescale 1ns/1ps

module int_div_assert (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_rdy,
  input logic                       resp_val,
  input logic                       resp_rdy,
  input div_msg_pkg::div_resp_msg_t resp_msg
);

  // number of assertion failures so far
  int unsigned failures = 0;

  // idle and done never overlap
  rdy_val_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val)
  ) else begin
    $error("req_rdy and resp_val high together");
    failures++;
  end

  // stalled response keeps its value
  resp_stable: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg))
  ) else begin
    $error("response changed or dropped while stalled");
    failures++;
  end

  // no response out of reset
  resp_low_after_reset: assert property (
    @(posedge clk) reset |=> !resp_val
  ) else begin
    $error("resp_val high right after reset");
    failures++;
  end

endmodule

bind int_div_iterative int_div_assert handshake_checks (
  .clk      (clk),
  .reset    (reset),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .resp_msg (resp_msg)
);

//--- int_div_tb.sv
// --------------------------------------
// testbench for the iterative divider
// tabled and random vectors with back-pressure and latency checks
// --------------------------------------

`timescale 1ns/1ps

module int_div_tb;

  localparam int unsigned dw           = div_msg_pkg::div_width;
  localparam int unsigned reset_cycles = 16;
  localparam int unsigned n_table      = 17;
  localparam int unsigned n_random     = 40;
  localparam int unsigned max_bp       = 8;
  // accept edge to first cycle with resp_val high
  localparam int unsigned resp_latency = 33;
  localparam int unsigned resp_limit   = 100;
  localparam time         drive_delay  = 1;
  localparam time         timeout_ns   =
    ((n_table + n_random) * (34 + max_bp) + reset_cycles) * 10 * 2;
  localparam logic [31:0] rand_seed    = 32'h2b07b9d5;

  // one test vector with its back-pressure cycle count in bp
  typedef struct packed {
    div_msg_pkg::div_fn_e fn;
    logic [dw-1:0]        a;
    logic [dw-1:0]        b;
    logic [dw-1:0]        rem;
    logic [dw-1:0]        quot;
    logic [3:0]           bp;
  } vector_t;

  logic                       clk = 1'b0;
  logic                       reset;
  div_msg_pkg::div_req_msg_t  req_msg;
  logic                       req_val;
  logic                       req_rdy;
  div_msg_pkg::div_resp_msg_t resp_msg;
  logic                       resp_val;
  logic                       resp_rdy;

  vector_t     vectors[$];
  int unsigned error_count  = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  int unsigned seed_dummy;

  int_div_iterative dut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 10 ns period
  always #5 clk = ~clk;

  // --------------------------------------
  // expected result from the division rule
  // --------------------------------------

  function automatic div_msg_pkg::div_resp_msg_t expected_result(
    div_msg_pkg::div_fn_e fn, logic [dw-1:0] a, logic [dw-1:0] b);
    logic                       a_neg;
    logic                       b_neg;
    logic [dw-1:0]              a_abs;
    logic [dw-1:0]              b_abs;
    logic [dw-1:0]              q_abs;
    logic [dw-1:0]              r_abs;
    div_msg_pkg::div_resp_msg_t res;
    a_neg = (fn == div_msg_pkg::div_fn_signed) && a[dw-1];
    b_neg = (fn == div_msg_pkg::div_fn_signed) && b[dw-1];
    a_abs = a_neg ? (32'd0 - a) : a;
    b_abs = b_neg ? (32'd0 - b) : b;
    // divide by zero gives all ones and the dividend magnitude
    if (b_abs == 0) begin
      q_abs = '1;
      r_abs = a_abs;
    end else begin
      q_abs = a_abs / b_abs;
      r_abs = a_abs % b_abs;
    end
    res.quot = (a_neg ^ b_neg) ? (32'd0 - q_abs) : q_abs;
    res.rem  = a_neg ? (32'd0 - r_abs) : r_abs;
    return res;
  endfunction

  task automatic add_vector(input div_msg_pkg::div_fn_e fn, input logic [dw-1:0] a,
                            input logic [dw-1:0] b, input logic [dw-1:0] rem,
                            input logic [dw-1:0] quot, input logic [3:0] bp);
    vector_t v;
    v = '{fn: fn, a: a, b: b, rem: rem, quot: quot, bp: bp};
    vectors.push_back(v);
  endtask

  // --------------------------------------
  // vector table
  // --------------------------------------

  task automatic fill_table();
    div_msg_pkg::div_fn_e u;
    div_msg_pkg::div_fn_e s;
    u = div_msg_pkg::div_fn_unsigned;
    s = div_msg_pkg::div_fn_signed;
    // unsigned with and without bit 31 set
    add_vector(u, 32'd100,        32'd7,        32'd2,        32'd14,       4'd0);
    add_vector(u, 32'hffffffff,   32'h00000010, 32'h0000000f, 32'h0fffffff, 4'd0);
    add_vector(u, 32'h80000000,   32'd3,        32'd2,        32'h2aaaaaaa, 4'd0);
    add_vector(u, 32'h12345678,   32'h12345678, 32'd0,        32'd1,        4'd0);
    add_vector(u, 32'd5,          32'd9,        32'd5,        32'd0,        4'd1);
    // all four sign combinations of signed operands
    add_vector(s, 32'd100,        32'd7,        32'd2,        32'd14,       4'd0);
    add_vector(s, 32'hffffff9c,   32'd7,        32'hfffffffe, 32'hfffffff2, 4'd3);
    add_vector(s, 32'd100,        32'hfffffff9, 32'd2,        32'hfffffff2, 4'd0);
    add_vector(s, 32'hffffff9c,   32'hfffffff9, 32'hfffffffe, 32'd14,       4'd0);
    // signed exact divisions
    add_vector(s, 32'hffffffd6,   32'd6,        32'd0,        32'hfffffff9, 4'd0);
    add_vector(s, 32'd42,         32'hfffffffa, 32'd0,        32'hfffffff9, 4'd0);
    add_vector(s, 32'h80000000,   32'hffffffff, 32'd0,        32'h80000000, 4'd0);
    // divide by zero
    add_vector(u, 32'd1234,       32'd0,        32'd1234,     32'hffffffff, 4'd0);
    add_vector(s, 32'hfffffffb,   32'd0,        32'hfffffffb, 32'd1,        4'd0);
    add_vector(s, 32'd7,          32'd0,        32'd7,        32'hffffffff, 4'd0);
    // long back-pressure
    add_vector(u, 32'hdeadbeef,   32'hffffffff, 32'hdeadbeef, 32'd0,        4'd5);
    add_vector(s, 32'h80000000,   32'd2,        32'd0,        32'hc0000000, 4'd8);
  endtask

  task automatic add_random_vectors();
    vector_t                    v;
    div_msg_pkg::div_resp_msg_t exp;
    for (int i = 0; i < n_random; i++) begin
      v.fn = ($urandom % 2) ? div_msg_pkg::div_fn_signed : div_msg_pkg::div_fn_unsigned;
      v.a  = $urandom;
      v.b  = $urandom;
      // small divisors give long quotients
      if ($urandom % 3 == 0) begin
        v.b = v.b >> ($urandom % dw);
      end
      if ($urandom % 16 == 0) begin
        v.b = '0;
      end
      exp    = expected_result(v.fn, v.a, v.b);
      v.rem  = exp.rem;
      v.quot = exp.quot;
      v.bp   = 4'($urandom % 4);
      vectors.push_back(v);
    end
  endtask

  // --------------------------------------
  // one request/response transaction
  // --------------------------------------

  task automatic check_hold(input int idx, input div_msg_pkg::div_resp_msg_t held);
    if (resp_msg != held) begin
      $display("[FAIL] %0t test %0d: resp_msg changed under back-pressure", $time, idx);
      error_count++;
    end
    if (!resp_val || req_rdy) begin
      $display("[FAIL] %0t test %0d: handshake moved under back-pressure", $time, idx);
      error_count++;
    end
  endtask

  task automatic run_test(input int idx, input vector_t v);
    div_msg_pkg::div_resp_msg_t held;
    int unsigned                n;
    int unsigned                errs_before;
    errs_before = error_count;
    @(posedge clk);
    #drive_delay;
    req_msg  = '{fn: v.fn, a: v.a, b: v.b};
    req_val  = 1'b1;
    resp_rdy = (v.bp == 0);
    @(negedge clk);
    if (!req_rdy) begin
      $display("[FAIL] %0t test %0d: unit was not ready for a new request", $time, idx);
      error_count++;
    end
    // accept edge
    @(posedge clk);
    #drive_delay;
    // a second request stays offered and must not be taken
    req_msg = '{fn: v.fn, a: ~v.a, b: v.b + 32'd1};
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (req_rdy) begin
        $display("[FAIL] %0t test %0d: req_rdy high while busy", $time, idx);
        error_count++;
      end
    end while (!resp_val && n < resp_limit);
    if (!resp_val) begin
      $display("test %0d: no response within %0d cycles", idx, resp_limit);
      error_count++;
    end else if (n != resp_latency) begin
      $display("[FAIL] %0t test %0d: resp_val after %0d cycles, expected %0d",
               $time, idx, n, resp_latency);
      error_count++;
    end
    held = resp_msg;
    if (held.quot != v.quot || held.rem != v.rem) begin
      $display("[FAIL] %0t test %0d: quot %h rem %h, expected quot %h rem %h",
               $time, idx, held.quot, held.rem, v.quot, v.rem);
      error_count++;
    end
    // resp_rdy stays low for exactly bp cycles of resp_val
    if (v.bp != 0) begin
      repeat (v.bp - 1) begin
        @(negedge clk);
        check_hold(idx, held);
      end
      @(posedge clk);
      #drive_delay;
      resp_rdy = 1'b1;
      @(negedge clk);
      check_hold(idx, held);
    end
    // response transfer edge
    @(posedge clk);
    #drive_delay;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    req_msg  = '0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      $display("[FAIL] %0t test %0d: not back in idle after the response", $time, idx);
      error_count++;
    end
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
    end
    $display("test %0d fn=%0d a=%h b=%h quot=%h rem=%h bp=%0d %s", idx, v.fn, v.a, v.b,
             held.quot, held.rem, v.bp, (error_count == errs_before) ? "ok" : "bad");
  endtask

  // --------------------------------------
  // watchdog
  // --------------------------------------

  initial begin
    #(timeout_ns * 1ns);
    $display("watchdog expired after %0t, the run did not finish", $time);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------
  // main sequence
  // --------------------------------------

  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b0;
    seed_dummy = $urandom(rand_seed);
    fill_table();
    add_random_vectors();
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
    // idle state before any request
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      $display("[FAIL] %0t after reset: req_rdy %b resp_val %b", $time, req_rdy, resp_val);
      error_count++;
    end
    for (int i = 0; i < vectors.size(); i++) begin
      run_test(i, vectors[i]);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, error_count,
             dut.handshake_checks.failures);
    if (error_count == 0 && dut.handshake_checks.failures == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
div_msg_pkg.sv
div_ctrl_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_iterative.sv
int_div_assert.sv
int_div_tb.sv

//--- Bender.yml
package:
  name: int_div_iterative

sources:
  - files:
      - div_msg_pkg.sv
      - div_ctrl_pkg.sv
      - int_div_dpath.sv
      - int_div_ctrl.sv
      - int_div_iterative.sv
  - target: test
    files:
      - int_div_assert.sv
      - int_div_tb.sv
